// File: hdl/dcachePkg.sv
package dcachePkg;

	// ----------------------------------------
	// cache geometry
	// ----------------------------------------
	localparam int AddrW = 32;
	// 32 byte lines, 5 offset bits
	localparam int LineBytes = 32;
	localparam int OffW = 5;
	localparam int LineBits = LineBytes * 8;
	// 16 sets x 4 ways = 64 lines
	localparam int NumSets = 16;
	localparam int SetW = 4;
	localparam int NumWays = 4;
	localparam int WayW = 2;
	localparam int NumLines = NumSets * NumWays;
	// tag is what is left of the address
	localparam int TagW = AddrW - SetW - OffW;
	// width of the load path word
	localparam int WordBytes = 8;
	// two fault bits stored next to each line
	localparam int FaultW = 2;

	// replacement LFSR, any nonzero seed works
	localparam int LfsrW = 16;
	localparam logic [LfsrW-1:0] LfsrSeed = 16'hACE1;

	// ----------------------------------------
	// maintenance register offsets
	// ----------------------------------------
	localparam logic [3:0] CsrInvAll = 4'h0;
	localparam logic [3:0] CsrInvLine = 4'h4;
	localparam logic [3:0] CsrHitCnt = 4'h8;
	localparam logic [3:0] CsrMissCnt = 4'hC;

	// byte address split into tag / set / offset
	typedef struct packed {
		logic [TagW-1:0] tag;
		logic [SetW-1:0] set;
		logic [OffW-1:0] off;
	} cacheAdr_t;

	// index into the line memory, way in the upper bits
	typedef struct packed {
		logic [WayW-1:0] way;
		logic [SetW-1:0] set;
	} lineNo_t;

	// one line load from the next memory level
	typedef struct packed {
		cacheAdr_t adr;
		logic [LineBytes-1:0] sel;
		logic [LineBits-1:0] data;
		logic [FaultW-1:0] fault;
	} fillReq_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [3:0] paddr;
		logic [31:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp_t;

endpackage

// File: hdl/wayLfsr.sv
module wayLfsr import dcachePkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            adv_i,
	output logic [WayW-1:0] way_o
);

	logic [LfsrW-1:0] state;
	logic feedback;

	// taps 16,14,13,11 give the maximal length sequence
	assign feedback = state[15] ^ state[13] ^ state[12] ^ state[10];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LfsrSeed;
		end else if (adv_i) begin
			// shift left, new bit enters at the bottom
			state <= {state[LfsrW-2:0], feedback};
		end
	end

	// low bits pick the victim way
	assign way_o = state[WayW-1:0];

	// an all zero state would lock the sequence up for good
	assert property (@(posedge clk) disable iff (rst) state != '0)
		else $error("way LFSR reached the all zero state");

endmodule

// File: hdl/dcacheTagWays.sv
module dcacheTagWays import dcachePkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  cacheAdr_t       rdAdr_i,
	input  logic            fillEn_i,
	input  cacheAdr_t       fillAdr_i,
	input  logic            invAll_i,
	input  logic            invLine_i,
	input  cacheAdr_t       invAdr_i,
	input  logic [WayW-1:0] victimWay_i,
	output logic            rdHit_o,
	output lineNo_t         rdLine_o,
	output lineNo_t         wrLine_o
);

	// one tag array and one valid vector per way
	logic [TagW-1:0] tagMem [NumWays][NumSets];
	logic [NumSets-1:0] valid [NumWays];

	cacheAdr_t mAdr;
	logic [NumWays-1:0] rdHitWay;
	logic [NumWays-1:0] mHitWay;
	logic [WayW-1:0] rdWay;
	logic [WayW-1:0] mWay;
	logic [WayW-1:0] fillWay;
	logic mHit;
	logic fillGo;

	// ----------------------------------------
	// compare
	// ----------------------------------------

	// maintenance port looks at the invalidate address while one is pending
	assign mAdr = (invAll_i || invLine_i) ? invAdr_i : fillAdr_i;

	always_comb begin
		for (int w = 0; w < NumWays; w++) begin
			rdHitWay[w] = valid[w][rdAdr_i.set] && (tagMem[w][rdAdr_i.set] == rdAdr_i.tag);
			mHitWay[w] = valid[w][mAdr.set] && (tagMem[w][mAdr.set] == mAdr.tag);
		end
	end

	// encode hit vectors to a way number, at most one bit is set
	always_comb begin
		rdWay = '0;
		mWay = '0;
		for (int w = 0; w < NumWays; w++) begin
			if (rdHitWay[w])
				rdWay = WayW'(w);
			if (mHitWay[w])
				mWay = WayW'(w);
		end
	end

	assign rdHit_o = |rdHitWay;
	assign rdLine_o = '{way: rdWay, set: rdAdr_i.set};
	assign mHit = |mHitWay;

	// invalidation takes priority, the fill is dropped
	assign fillGo = fillEn_i && !invAll_i && !invLine_i;
	// refill in place on a hit, else take the LFSR way
	assign fillWay = mHit ? mWay : victimWay_i;

	// ----------------------------------------
	// update
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NumWays; w++)
				valid[w] <= '0;
		end else if (invAll_i) begin
			for (int w = 0; w < NumWays; w++)
				valid[w] <= '0;
		end else if (invLine_i) begin
			// only the way holding the address is dropped
			for (int w = 0; w < NumWays; w++) begin
				if (mHitWay[w])
					valid[w][mAdr.set] <= 1'b0;
			end
		end else if (fillEn_i && !mHit) begin
			valid[victimWay_i][mAdr.set] <= 1'b1;
		end
	end

	// tag only changes on a fill miss
	always_ff @(posedge clk) begin
		if (fillGo && !mHit)
			tagMem[victimWay_i][fillAdr_i.set] <= fillAdr_i.tag;
	end

	// line for the data write one cycle later
	always_ff @(posedge clk) begin
		if (rst) begin
			wrLine_o <= '0;
		end else if (fillGo) begin
			wrLine_o <= '{way: fillWay, set: fillAdr_i.set};
		end
	end

	// fills must never leave two ways holding the same tag in a set
	assert property (@(posedge clk) disable iff (rst) $onehot0(rdHitWay) && $onehot0(mHitWay))
		else $error("more than one way hits a single address");

endmodule

// File: hdl/dcacheLineMem.sv
module dcacheLineMem import dcachePkg::*; (
	input  logic                 clk,
	input  logic                 wrEn_i,
	input  lineNo_t              wrLine_i,
	input  logic [LineBytes-1:0] sel_i,
	input  logic [LineBits-1:0]  data_i,
	input  logic [FaultW-1:0]    fault_i,
	input  lineNo_t              rdLine_i,
	output logic [LineBits-1:0]  data_o,
	output logic [FaultW-1:0]    fault_o
);

	// distributed style storage, indexed by {way, set}
	logic [LineBits-1:0] dataMem [NumLines];
	logic [FaultW-1:0] faultMem [NumLines];

	// byte lanes written only where selected
	always_ff @(posedge clk) begin
		if (wrEn_i) begin
			for (int b = 0; b < LineBytes; b++) begin
				if (sel_i[b])
					dataMem[wrLine_i][b*8 +: 8] <= data_i[b*8 +: 8];
			end
		end
	end

	// fault bits follow every write, partial or not
	always_ff @(posedge clk) begin
		if (wrEn_i)
			faultMem[wrLine_i] <= fault_i;
	end

	// read is combinational from the line number
	assign data_o = dataMem[rdLine_i];
	assign fault_o = faultMem[rdLine_i];

endmodule

// File: hdl/dcacheMaintApb.sv
module dcacheMaintApb import dcachePkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  apbReq_t   apb_i,
	output apbRsp_t   apb_o,
	input  logic      rdEn_i,
	input  logic      rdHit_i,
	output logic      invAll_o,
	output logic      invLine_o,
	output cacheAdr_t invAdr_o
);

	logic access;
	logic wrAccess;
	logic [31:0] hitCnt;
	logic [31:0] missCnt;
	logic [31:0] rdData;
	logic isReg;
	logic isRo;
	logic slvErr;

	// access phase of a transfer, pready is always high
	assign access = apb_i.psel && apb_i.penable;
	assign wrAccess = access && apb_i.pwrite;

	// ----------------------------------------
	// register decode
	// ----------------------------------------
	always_comb begin
		rdData = '0;
		isReg = 1'b1;
		isRo = 1'b0;
		case (apb_i.paddr)
			// command registers read back as zero
			CsrInvAll, CsrInvLine: rdData = '0;
			CsrHitCnt: begin
				rdData = hitCnt;
				isRo = 1'b1;
			end
			CsrMissCnt: begin
				rdData = missCnt;
				isRo = 1'b1;
			end
			default: isReg = 1'b0;
		endcase
	end

	// error on unknown offsets and on writes to the counters
	assign slvErr = access && (!isReg || (apb_i.pwrite && isRo));
	assign apb_o = '{prdata: rdData, pready: 1'b1, pslverr: slvErr};

	// invalidate pulses, one cycle after the access
	always_ff @(posedge clk) begin
		if (rst) begin
			invAll_o <= 1'b0;
			invLine_o <= 1'b0;
		end else begin
			invAll_o <= wrAccess && (apb_i.paddr == CsrInvAll) && apb_i.pwdata[0];
			invLine_o <= wrAccess && (apb_i.paddr == CsrInvLine);
		end
	end

	// address held for the tag compare
	always_ff @(posedge clk) begin
		if (wrAccess && (apb_i.paddr == CsrInvLine))
			invAdr_o <= cacheAdr_t'(apb_i.pwdata[AddrW-1:0]);
	end

	// lookup statistics, both wrap
	always_ff @(posedge clk) begin
		if (rst) begin
			hitCnt <= '0;
			missCnt <= '0;
		end else if (rdEn_i) begin
			if (rdHit_i)
				hitCnt <= hitCnt + 32'd1;
			else
				missCnt <= missCnt + 32'd1;
		end
	end

	// access phase always comes out of a setup phase
	assert property (@(posedge clk) disable iff (rst)
		apb_i.penable |-> apb_i.psel && $past(apb_i.psel))
		else $error("APB penable without a preceding psel");

endmodule

// File: hdl/l1Dcache.sv
module l1Dcache import dcachePkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	// lookup
	input  cacheAdr_t              adr_i,
	input  logic                   rdEn_i,
	output logic                   hit_o,
	output logic [WordBytes*8-1:0] rdata_o,
	output logic [FaultW-1:0]      fault_o,
	// line fill
	input  logic                   fillEn_i,
	input  fillReq_t               fill_i,
	// maintenance
	input  apbReq_t                apb_i,
	output apbRsp_t                apb_o
);

	lineNo_t rdLine;
	lineNo_t wrLine;
	logic rdHit;
	logic [WayW-1:0] victimWay;
	logic invAll;
	logic invLine;
	cacheAdr_t invAdr;

	logic fillEnQ;
	logic [LineBytes-1:0] fillSelQ;
	logic [LineBits-1:0] fillDataQ;
	logic [FaultW-1:0] fillFaultQ;
	logic [LineBits-1:0] lineData;
	logic [LineBits-1:0] lineShift;

	// ----------------------------------------
	// fill pipeline
	// ----------------------------------------

	// data lands one edge after the tag, when wrLine is known
	// a fill lost to an invalidate writes no data either
	always_ff @(posedge clk) begin
		if (rst)
			fillEnQ <= 1'b0;
		else
			fillEnQ <= fillEn_i && !invAll && !invLine;
	end

	always_ff @(posedge clk) begin
		fillSelQ <= fill_i.sel;
		fillDataQ <= fill_i.data;
		fillFaultQ <= fill_i.fault;
	end

	// replacement moves on with each fill
	wayLfsr i_wayLfsr (
		.clk   (clk),
		.rst   (rst),
		.adv_i (fillEn_i),
		.way_o (victimWay)
	);

	dcacheTagWays i_dcacheTagWays (
		.clk         (clk),
		.rst         (rst),
		.rdAdr_i     (adr_i),
		.fillEn_i    (fillEn_i),
		.fillAdr_i   (fill_i.adr),
		.invAll_i    (invAll),
		.invLine_i   (invLine),
		.invAdr_i    (invAdr),
		.victimWay_i (victimWay),
		.rdHit_o     (rdHit),
		.rdLine_o    (rdLine),
		.wrLine_o    (wrLine)
	);

	dcacheLineMem i_dcacheLineMem (
		.clk      (clk),
		.wrEn_i   (fillEnQ),
		.wrLine_i (wrLine),
		.sel_i    (fillSelQ),
		.data_i   (fillDataQ),
		.fault_i  (fillFaultQ),
		.rdLine_i (rdLine),
		.data_o   (lineData),
		.fault_o  (fault_o)
	);

	dcacheMaintApb i_dcacheMaintApb (
		.clk       (clk),
		.rst       (rst),
		.apb_i     (apb_i),
		.apb_o     (apb_o),
		.rdEn_i    (rdEn_i),
		.rdHit_i   (rdHit),
		.invAll_o  (invAll),
		.invLine_o (invLine),
		.invAdr_o  (invAdr)
	);

	// ----------------------------------------
	// read alignment
	// ----------------------------------------

	// byte offset shift, zeros come in past the end of the line
	assign lineShift = lineData >> {adr_i.off, 3'b000};
	assign rdata_o = lineShift[WordBytes*8-1:0];
	assign hit_o = rdHit;

endmodule

// File: dv/l1DcacheTable.svh
`ifndef L1DCACHE_TABLE_SVH
`define L1DCACHE_TABLE_SVH

// what a table step does
typedef enum logic [2:0] {
	OpFill,
	OpRead,
	OpProbe,
	OpReplChk,
	OpApbWr,
	OpApbRd
} stepOp_t;

typedef struct {
	string name;
	stepOp_t op;
	logic [3:0] csr;
	logic [31:0] adr;
	logic [31:0] sel;
	logic [31:0] seed;
	logic [31:0] exp;
} step_t;

localparam int NumSteps = 34;

// columns: name, op, csr offset, address or APB write data, byte select, data seed,
// expected (hit flag for reads and probes, pslverr for APB steps)
step_t steps [NumSteps] = '{
	// lines in distinct sets, full selects
	'{"fill_l1",      OpFill,    4'h0,       32'h0001_2020, 32'hFFFF_FFFF, 32'h0000_0011, 32'd0},
	'{"fill_l2",      OpFill,    4'h0,       32'h0003_4040, 32'hFFFF_FFFF, 32'h0000_0022, 32'd0},
	'{"fill_l3",      OpFill,    4'h0,       32'h0005_6060, 32'hFFFF_FFFF, 32'h0000_0033, 32'd0},
	'{"rd_l1_off0",   OpRead,    4'h0,       32'h0001_2020, 32'h0,         32'h0,         32'd1},
	'{"rd_l1_off3",   OpRead,    4'h0,       32'h0001_2023, 32'h0,         32'h0,         32'd1},
	'{"rd_l2_off24",  OpRead,    4'h0,       32'h0003_4058, 32'h0,         32'h0,         32'd1},
	'{"rd_l2_off27",  OpRead,    4'h0,       32'h0003_405B, 32'h0,         32'h0,         32'd1},
	'{"rd_l3_off31",  OpRead,    4'h0,       32'h0005_607F, 32'h0,         32'h0,         32'd1},
	// sparse refill of a cached line
	'{"fill_l2_part", OpFill,    4'h0,       32'h0003_4040, 32'h0100_8421, 32'h0000_0044, 32'd0},
	'{"rd_l2p_off0",  OpRead,    4'h0,       32'h0003_4040, 32'h0,         32'h0,         32'd1},
	'{"rd_l2p_off15", OpRead,    4'h0,       32'h0003_404F, 32'h0,         32'h0,         32'd1},
	'{"rd_l2p_off24", OpRead,    4'h0,       32'h0003_4058, 32'h0,         32'h0,         32'd1},
	'{"rd_never",     OpRead,    4'h0,       32'h0007_80E0, 32'h0,         32'h0,         32'd0},
	// five tags into set 5
	'{"fill_r1",      OpFill,    4'h0,       32'h0010_00A0, 32'hFFFF_FFFF, 32'h0000_0051, 32'd0},
	'{"fill_r2",      OpFill,    4'h0,       32'h0011_00A0, 32'hFFFF_FFFF, 32'h0000_0052, 32'd0},
	'{"fill_r3",      OpFill,    4'h0,       32'h0012_00A0, 32'hFFFF_FFFF, 32'h0000_0053, 32'd0},
	'{"fill_r4",      OpFill,    4'h0,       32'h0013_00A0, 32'hFFFF_FFFF, 32'h0000_0054, 32'd0},
	'{"fill_r5",      OpFill,    4'h0,       32'h0014_00A0, 32'hFFFF_FFFF, 32'h0000_0055, 32'd0},
	'{"probe_r1",     OpProbe,   4'h0,       32'h0010_00A0, 32'h0,         32'h0,         32'd0},
	'{"probe_r2",     OpProbe,   4'h0,       32'h0011_00A0, 32'h0,         32'h0,         32'd0},
	'{"probe_r3",     OpProbe,   4'h0,       32'h0012_00A0, 32'h0,         32'h0,         32'd0},
	'{"probe_r4",     OpProbe,   4'h0,       32'h0013_00A0, 32'h0,         32'h0,         32'd0},
	'{"probe_r5",     OpProbe,   4'h0,       32'h0014_00A0, 32'h0,         32'h0,         32'd0},
	'{"repl_count",   OpReplChk, 4'h0,       32'h0,         32'h0,         32'h0,         32'd0},
	// maintenance
	'{"inv_line_l1",  OpApbWr,   CsrInvLine, 32'h0001_2020, 32'h0,         32'h0,         32'd0},
	'{"rd_l1_gone",   OpRead,    4'h0,       32'h0001_2020, 32'h0,         32'h0,         32'd0},
	'{"rd_l3_kept",   OpRead,    4'h0,       32'h0005_6060, 32'h0,         32'h0,         32'd1},
	'{"hit_count",    OpApbRd,   CsrHitCnt,  32'h0,         32'h0,         32'h0,         32'd0},
	'{"miss_count",   OpApbRd,   CsrMissCnt, 32'h0,         32'h0,         32'h0,         32'd0},
	'{"bad_offset",   OpApbRd,   4'h3,       32'h0,         32'h0,         32'h0,         32'd1},
	'{"inv_all",      OpApbWr,   CsrInvAll,  32'h0000_0001, 32'h0,         32'h0,         32'd0},
	'{"rd_l2_gone",   OpRead,    4'h0,       32'h0003_4040, 32'h0,         32'h0,         32'd0},
	'{"rd_l3_gone",   OpRead,    4'h0,       32'h0005_6060, 32'h0,         32'h0,         32'd0},
	'{"miss_final",   OpApbRd,   CsrMissCnt, 32'h0,         32'h0,         32'h0,         32'd0}
};

`endif

// File: dv/l1DcacheTb.sv
module l1DcacheTb import dcachePkg::*; ();

	localparam int ClkPeriod = 4;
	localparam int MaxSlots = 16;

	`include "l1DcacheTable.svh"

	logic clk;
	logic rst;
	cacheAdr_t adr;
	logic rdEn;
	logic hit;
	logic [WordBytes*8-1:0] rdata;
	logic [FaultW-1:0] fault;
	logic fillEn;
	fillReq_t fill;
	apbReq_t apbReq;
	apbRsp_t apbRsp;

	// reference model, one entry per filled line address
	logic [31:0] mLineAdr [MaxSlots];
	logic [7:0] mData [MaxSlots][LineBytes];
	logic [FaultW-1:0] mFault [MaxSlots];
	int slotCnt;
	int modelHits;
	int modelMisses;
	int replHits;

	integer seed;
	logic stepOk;
	int passCnt;
	int failCnt;

	l1Dcache i_l1Dcache (
		.clk      (clk),
		.rst      (rst),
		.adr_i    (adr),
		.rdEn_i   (rdEn),
		.hit_o    (hit),
		.rdata_o  (rdata),
		.fault_o  (fault),
		.fillEn_i (fillEn),
		.fill_i   (fill),
		.apb_i    (apbReq),
		.apb_o    (apbRsp)
	);

	always #(ClkPeriod/2) clk = ~clk;

	// ----------------------------------------
	// model helpers
	// ----------------------------------------

	function automatic int findSlot(input logic [31:0] lineAdr);
		int idx;
		idx = -1;
		for (int s = 0; s < slotCnt; s++) begin
			if (mLineAdr[s] == lineAdr)
				idx = s;
		end
		return idx;
	endfunction

	// bytes from the offset on, zero past the line end
	function automatic logic [63:0] expectedWord(input int slot, input int off);
		logic [63:0] w;
		w = '0;
		for (int b = 0; b < WordBytes; b++) begin
			if (off + b < LineBytes)
				w[b*8 +: 8] = mData[slot][off + b];
		end
		return w;
	endfunction

	// ----------------------------------------
	// drivers
	// ----------------------------------------

	task automatic applyFill(input step_t st);
		logic [31:0] rnd;
		logic [31:0] lineAdr;
		int slot;
		lineAdr = {st.adr[31:OffW], {OffW{1'b0}}};
		slot = findSlot(lineAdr);
		if (slot < 0 && slotCnt == MaxSlots) begin
			$display("%s: the reference model has no free entry for this line", st.name);
			stepOk = 1'b0;
			return;
		end
		if (slot < 0) begin
			slot = slotCnt;
			mLineAdr[slot] = lineAdr;
			slotCnt++;
		end
		@(posedge clk);
		#1;
		fill.adr = cacheAdr_t'(lineAdr);
		fill.sel = st.sel;
		// table seed mixed into every random word
		for (int w = 0; w < LineBytes / 4; w++) begin
			rnd = $random(seed) ^ st.seed;
			fill.data[w*32 +: 32] = rnd;
		end
		rnd = $random(seed);
		fill.fault = rnd[FaultW-1:0];
		fillEn = 1'b1;
		// only selected bytes move, fault bits always do
		for (int b = 0; b < LineBytes; b++) begin
			if (st.sel[b])
				mData[slot][b] = fill.data[b*8 +: 8];
		end
		mFault[slot] = fill.fault;
		@(posedge clk);
		#1;
		fillEn = 1'b0;
		// tag and data writes settle before any read
		repeat (3) @(posedge clk);
	endtask

	task automatic lookupAndCheck(input step_t st, input logic counted);
		int slot;
		logic [63:0] expWord;
		slot = findSlot({st.adr[31:OffW], {OffW{1'b0}}});
		@(posedge clk);
		#1;
		adr = cacheAdr_t'(st.adr);
		rdEn = counted;
		// outputs are combinational, look just before the next edge
		#2;
		if (counted && hit !== st.exp[0]) begin
			$display("[ERROR] %s: hit expected %b, actual %b", st.name, st.exp[0], hit);
			stepOk = 1'b0;
		end
		if (hit === 1'b1 && (counted ? st.exp[0] : 1'b1)) begin
			if (slot < 0) begin
				$display("%s: the address hits but was never filled", st.name);
				stepOk = 1'b0;
			end else begin
				expWord = expectedWord(slot, st.adr[OffW-1:0]);
				if (rdata !== expWord) begin
					$display("[ERROR] %s: rdata expected %h, actual %h", st.name, expWord, rdata);
					stepOk = 1'b0;
				end
				if (fault !== mFault[slot]) begin
					$display("[ERROR] %s: fault expected %b, actual %b", st.name,
						mFault[slot], fault);
					stepOk = 1'b0;
				end
			end
		end
		if (counted && st.exp[0])
			modelHits++;
		else if (counted)
			modelMisses++;
		if (!counted && hit === 1'b1)
			replHits++;
		@(posedge clk);
		#1;
		rdEn = 1'b0;
	endtask

	task automatic checkReplacement(input step_t st);
		// newest fill always survives, five tags cannot all fit in four ways
		if (replHits < 1 || replHits > NumWays) begin
			$display("[ERROR] %s: hits expected 1 to %0d, actual %0d", st.name, NumWays, replHits);
			stepOk = 1'b0;
		end
	endtask

	task automatic apbAccess(input step_t st, input logic write);
		logic [31:0] expData;
		@(posedge clk);
		#1;
		apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: st.csr, pwdata: st.adr};
		@(posedge clk);
		#1;
		apbReq.penable = 1'b1;
		#2;
		if (apbRsp.pready !== 1'b1) begin
			$display("%s: pready was low in the access cycle", st.name);
			stepOk = 1'b0;
		end
		if (apbRsp.pslverr !== st.exp[0]) begin
			$display("[ERROR] %s: pslverr expected %b, actual %b", st.name, st.exp[0],
				apbRsp.pslverr);
			stepOk = 1'b0;
		end
		// counters come from the model tally of counted lookups
		if (!write && (st.csr == CsrHitCnt || st.csr == CsrMissCnt)) begin
			expData = (st.csr == CsrHitCnt) ? 32'(modelHits) : 32'(modelMisses);
			if (apbRsp.prdata !== expData) begin
				$display("[ERROR] %s: prdata expected %h, actual %h", st.name, expData,
					apbRsp.prdata);
				stepOk = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		apbReq = '0;
		// invalidate pulse lands one edge after the access
		repeat (2) @(posedge clk);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		adr = '0;
		rdEn = 1'b0;
		fillEn = 1'b0;
		fill = '0;
		apbReq = '0;
		seed = 32'h3811f489;
		slotCnt = 0;
		modelHits = 0;
		modelMisses = 0;
		replHits = 0;
		passCnt = 0;
		failCnt = 0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < NumSteps; i++) begin
			stepOk = 1'b1;
			case (steps[i].op)
				OpFill: applyFill(steps[i]);
				OpRead: lookupAndCheck(steps[i], 1'b1);
				// probes leave rdEn low so the counters stay untouched
				OpProbe: lookupAndCheck(steps[i], 1'b0);
				OpReplChk: checkReplacement(steps[i]);
				OpApbWr: apbAccess(steps[i], 1'b1);
				default: apbAccess(steps[i], 1'b0);
			endcase
			if (stepOk)
				passCnt++;
			else
				failCnt++;
			$display("%-14s %s", steps[i].name, stepOk ? "pass" : "fail");
		end
		$display("steps: %0d passed, %0d failed", passCnt, failCnt);
		if (failCnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog, 20 cycles per table step plus reset
	initial begin
		#((NumSteps * 20 + 5) * ClkPeriod);
		$display("timeout: the table did not finish within %0d cycles", NumSteps * 20 + 5);
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+dv
hdl/dcachePkg.sv
hdl/wayLfsr.sv
hdl/dcacheTagWays.sv
hdl/dcacheLineMem.sv
hdl/dcacheMaintApb.sv
hdl/l1Dcache.sv
dv/l1DcacheTb.sv
